//--- all.f
hdl/video_stream_pkg.sv
hdl/video_timing_gen.sv
hdl/video_to_axis.sv
hdl/stream_fifo.sv
hdl/video_stream_top.sv
tests/video_stream_assertions.sv
tests/tb_video_stream.sv

//--- Makefile
# Verilator build and run of the video stream testbench.
# Select the packet mode with MODE=LINE or MODE=FRAME.

VERILATOR ?= verilator
MODE      ?= LINE
TOP       ?= tb_video_stream
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
PASS_TEXT ?= TB PASSED
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gmode='"$(MODE)"' \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_video_stream.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_stream #(
    parameter string mode = "LINE"  // Packet boundary under test.
);
    import video_stream_pkg::*;

    localparam int clk_period = 20;
    localparam int raster     = h_total * v_total;  // Clocks per frame.
    localparam int run_frames = 9;                  // Frames plus drain and idle windows.
    localparam int timeout_ns = run_frames * raster * 2 * clk_period;
    localparam logic [16:0] lfsr_seed = 17'd79555;

    logic         clock;
    logic         rst_n;
    logic         enable;
    logic         out_ready;
    logic         out_valid;
    logic         overflow;
    stream_beat_t out_beat;

    logic         ready_random;  // Random stalls when set.
    logic         ready_hold;    // Fixed ready level otherwise.
    logic [16:0]  lfsr;
    int           rx_count;      // Beat index within the current run.

    video_stream_top #(
        .mode (mode)
    ) i_video_stream_top (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .overflow  (overflow)
    );

    bind video_stream_top video_stream_assertions i_video_stream_assertions (
        .clock     (clock),
        .rst_n     (rst_n),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .overflow  (overflow)
    );

    always #(clk_period / 2) clock = ~clock;

    // Fibonacci LFSR with taps 17 and 14.
    function automatic logic [16:0] lfsr_step(input logic [16:0] state);
        logic feedback;
        feedback = state[16] ^ state[13];
        return {state[15:0], feedback};
    endfunction

    // Expected pattern pixel with the line in the upper byte and the column in the lower.
    function automatic pixel_t pattern_pixel(input int idx);
        int line;
        int col;
        line = (idx / h_active) % v_active;
        col  = idx % h_active;
        return pixel_t'((line << (pixel_w / 2)) | col);
    endfunction

    function automatic logic packet_end_at(input int idx);
        if (mode == "FRAME") begin
            return (idx % frame_beats) == (frame_beats - 1);
        end else begin
            return (idx % h_active) == (h_active - 1);
        end
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock);
    endtask

    // Waits for the FIFO to empty and requires it to stay empty.
    task automatic drain_then_idle(input int idle_clocks);
        @(posedge clock);
        while (out_valid) begin
            @(posedge clock);
        end
        repeat (idle_clocks) begin
            @(posedge clock);
            check_value(32'(out_valid), 32'd0, "out_valid after the FIFO drained");
        end
    endtask

    // Sink ready from three LFSR bits per clock in random mode.
    always @(posedge clock) begin : drive_ready
        logic [2:0] bits;
        if (ready_random) begin
            for (int i = 0; i < 3; i++) begin
                lfsr    = lfsr_step(lfsr);
                bits[i] = lfsr[0];
            end
            out_ready <= (bits != 3'b000);  // Stall one clock in eight.
        end else begin
            out_ready <= ready_hold;
        end
    end

    // Every transfer against the reference pattern.
    always @(posedge clock) begin : compare_beats
        if (rst_n && out_valid && out_ready) begin
            check_value(32'(out_beat.data), 32'(pattern_pixel(rx_count)),
                        $sformatf("pixel of beat %0d", rx_count));
            check_value(32'(out_beat.last), 32'(packet_end_at(rx_count)),
                        $sformatf("last of beat %0d", rx_count));
            rx_count = rx_count + 1;
        end
    end

    // A failed bound assertion ends the run.
    always @(posedge clock) begin : watch_assertions
        if (i_video_stream_top.i_video_stream_assertions.error_count != 0) begin
            $display("a bound assertion on the stream port failed");
            $display("TB FAILED");
            $fatal(1, "assertion failed");
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout after %0d ns, the expected beats never arrived", timeout_ns);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        enable       = 1'b0;
        out_ready    = 1'b0;
        ready_random = 1'b0;
        ready_hold   = 1'b0;
        lfsr         = lfsr_seed;
        rx_count     = 0;
        wait_clocks(2);
        rst_n <= 1'b1;
        @(posedge clock);
        check_value(32'(out_valid), 32'd0, "out_valid after reset");
        check_value(32'(overflow), 32'd0, "overflow after reset");

        // Three frames under random stalls.
        ready_random <= 1'b1;
        enable       <= 1'b1;
        wait_clocks(3 * raster - raster / 2);  // Falls inside the third frame.
        enable <= 1'b0;
        wait (rx_count == 3 * frame_beats);
        drain_then_idle(raster);
        check_value(32'(rx_count), 32'(3 * frame_beats), "beats delivered in three frames");
        check_value(32'(overflow), 32'd0, "overflow under random stalls");

        // One frame into a stalled sink where only fifo_depth beats fit.
        rx_count = 0;
        ready_random <= 1'b0;
        ready_hold   <= 1'b0;
        enable       <= 1'b1;
        @(posedge clock);
        enable <= 1'b0;
        wait_clocks(raster + h_total);
        check_value(32'(overflow), 32'd1, "overflow after a full frame of stall");
        ready_hold <= 1'b1;
        wait (rx_count == fifo_depth);
        drain_then_idle(raster);
        check_value(32'(rx_count), 32'(fifo_depth), "beats kept through the overflow");
        check_value(32'(overflow), 32'd1, "overflow held until reset");

        // Reset clears the flag and a new run starts at line 0 column 0.
        rst_n      <= 1'b0;
        ready_hold <= 1'b0;
        wait_clocks(2);
        rst_n <= 1'b1;
        rx_count = 0;
        @(posedge clock);
        check_value(32'(overflow), 32'd0, "overflow after the second reset");
        check_value(32'(out_valid), 32'd0, "out_valid after the second reset");
        ready_random <= 1'b1;
        enable       <= 1'b1;
        wait_clocks(raster / 2);
        enable <= 1'b0;
        wait (rx_count == frame_beats);
        drain_then_idle(raster);
        check_value(32'(rx_count), 32'(frame_beats), "beats delivered after reset");
        check_value(32'(overflow), 32'd0, "overflow after reset run");

        if (i_video_stream_top.i_video_stream_assertions.error_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("a bound assertion on the stream port failed");
            $display("TB FAILED");
            $fatal(1, "assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- tests/video_stream_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module video_stream_assertions (
    input logic                           clock,
    input logic                           rst_n,
    input video_stream_pkg::stream_beat_t out_beat,
    input logic                           out_valid,
    input logic                           out_ready,
    input logic                           overflow
);

    int error_count = 0;  // Failed assertions so far.

    // A stalled beat stays put until the sink takes it.
    property beat_held;
        @(posedge clock) disable iff (!rst_n)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_beat));
    endproperty

    property quiet_in_reset;
        @(posedge clock) !rst_n |-> (!out_valid && !overflow);
    endproperty

    // Sticky flag.
    property overflow_sticky;
        @(posedge clock) disable iff (!rst_n) !$fell(overflow);
    endproperty

    a_beat_held: assert property (beat_held)
        else begin
            error_count = error_count + 1;
            $error("out_beat changed or out_valid dropped during a stall");
        end

    a_quiet_in_reset: assert property (quiet_in_reset)
        else begin
            error_count = error_count + 1;
            $error("out_valid or overflow high during reset");
        end

    a_overflow_sticky: assert property (overflow_sticky)
        else begin
            error_count = error_count + 1;
            $error("overflow fell outside reset");
        end

endmodule

`default_nettype wire

//--- hdl/video_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_stream_top #(
    parameter string mode = "LINE"  // Packet boundary, per line or per frame.
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          enable,
    output video_stream_pkg::stream_beat_t out_beat,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic                          overflow
);
    import video_stream_pkg::*;

    video_native_t video;       // Free-running raster, no handshake.
    stream_beat_t  beat;
    logic          beat_valid;

    // Input side, timing and test pattern.
    video_timing_gen i_video_timing_gen (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (enable),
        .video  (video)
    );

    video_to_axis #(
        .mode (mode)
    ) i_video_to_axis (
        .clock      (clock),
        .rst_n      (rst_n),
        .video      (video),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

    // Output side absorbs sink stalls.
    stream_fifo i_stream_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_beat   (beat),
        .in_valid  (beat_valid),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

//--- hdl/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo (
    input  logic                          clock,
    input  logic                          rst_n,
    input  video_stream_pkg::stream_beat_t in_beat,
    input  logic                          in_valid,
    output video_stream_pkg::stream_beat_t out_beat,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic                          overflow
);
    import video_stream_pkg::*;

    stream_beat_t          mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  full;
    logic                  wr_en;
    logic                  rd_en;

    // Pointer advance with explicit wrap for any depth.
    function automatic logic [fifo_ptr_w-1:0] ptr_next(input logic [fifo_ptr_w-1:0] ptr);
        if (ptr == fifo_ptr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == fifo_cnt_w'(fifo_depth));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];  // Head of queue, held until popped.
    assign rd_en     = out_valid && out_ready;
    assign wr_en     = in_valid && (!full || rd_en);  // A pop frees the slot.

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
        end
    end

    // Occupancy.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Sticky until reset, a dropped beat is never recovered.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (in_valid && !wr_en) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/video_to_axis.sv
`timescale 1ns/1ps
`default_nettype none

module video_to_axis #(
    parameter string mode = "LINE"  // "LINE" or "FRAME", anything else acts as LINE.
) (
    input  logic                           clock,
    input  logic                           rst_n,
    input  video_stream_pkg::video_native_t video,
    output video_stream_pkg::stream_beat_t  beat,
    output logic                           beat_valid
);
    import video_stream_pkg::*;

    localparam bit is_frame  = (mode == "FRAME");
    localparam int burst_len = is_frame ? frame_beats : h_active;
    localparam logic [beat_cnt_w-1:0] last_idx = beat_cnt_w'(burst_len - 1);

    logic                  hs_q;
    logic                  vs_q;
    logic                  hs_rise;
    logic                  hs_fall;
    logic                  vs_rise;
    logic                  vs_fall;
    logic [v_cnt_w-1:0]    line_cnt;
    logic                  pkt_open;
    logic                  pkt_start;
    logic                  pkt_end;
    logic [beat_cnt_w-1:0] beat_cnt;

    // Sync edge detection.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hs_q <= 1'b0;
            vs_q <= 1'b0;
        end else begin
            hs_q <= video.hs;
            vs_q <= video.vs;
        end
    end

    assign hs_rise = video.hs && !hs_q;
    assign hs_fall = !video.hs && hs_q;
    assign vs_rise = video.vs && !vs_q;
    assign vs_fall = !video.vs && vs_q;

    // Raster line index. The vs line is line 0, active lines follow the blanking.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            line_cnt <= '0;
        end else if (vs_rise) begin
            line_cnt <= '0;
        end else if (hs_rise) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

    assign pkt_start = is_frame ? vs_fall : (hs_fall && (line_cnt >= v_cnt_w'(v_blank)));
    assign pkt_end   = pkt_open && video.de && (beat_cnt == last_idx);

    // Packet window and beat position inside it.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pkt_open <= 1'b0;
            beat_cnt <= '0;
        end else if (pkt_end) begin
            pkt_open <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (pkt_start) begin
                pkt_open <= 1'b1;
            end
            if (pkt_open && video.de) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= pkt_open && video.de;  // One clock behind de.
        end
    end

    // Beat payload.
    always_ff @(posedge clock) begin
        if (video.de) begin
            beat.data <= video.data;
        end
        beat.last <= pkt_end;
    end

endmodule

`default_nettype wire

//--- hdl/video_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing_gen (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          enable,
    output video_stream_pkg::video_native_t video
);
    import video_stream_pkg::*;

    logic               running;
    logic [h_cnt_w-1:0] h_cnt;
    logic [v_cnt_w-1:0] v_cnt;
    logic               line_end;
    logic               frame_end;
    logic               h_act;
    logic               v_act;
    logic [coord_w-1:0] row;
    logic [coord_w-1:0] col;
    video_native_t      sample;

    assign line_end  = (h_cnt == h_cnt_w'(h_total - 1));
    assign frame_end = line_end && (v_cnt == v_cnt_w'(v_total - 1));

    // Run control. Starts on a frame boundary and always finishes the frame.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
        end else if (!running) begin
            running <= enable;
        end else if (frame_end && !enable) begin
            running <= 1'b0;
        end
    end

    // Raster counters, idle at zero so the next start is at line 0.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (running) begin
            if (line_end) begin
                h_cnt <= '0;
                if (frame_end) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // Blanking comes first in both directions.
    assign h_act = (h_cnt >= h_cnt_w'(h_blank));
    assign v_act = (v_cnt >= v_cnt_w'(v_blank));

    // Pattern coordinates, only meaningful inside the active area.
    assign row = coord_w'(v_cnt - v_cnt_w'(v_blank));
    assign col = coord_w'(h_cnt - h_cnt_w'(h_blank));

    always_comb begin
        sample.vs = running && (v_cnt == '0);  // Whole first blanking line.
        sample.hs = running && (h_cnt == '0);  // First blanking pixel.
        sample.de = running && h_act && v_act;
        if (sample.de) begin
            sample.data = {row, col};
        end else begin
            sample.data = '0;
        end
    end

    // Registered outputs.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            video <= '0;
        end else begin
            video <= sample;
        end
    end

endmodule

`default_nettype wire

//--- hdl/video_stream_pkg.sv
`default_nettype none

package video_stream_pkg;

    // Raster geometry, blanking included in the totals.
    localparam int h_active = 16;  // Pixels per active line.
    localparam int h_blank  = 4;   // Blanking pixels at the start of a line.
    localparam int v_active = 6;   // Active lines per frame.
    localparam int v_blank  = 2;   // Blanking lines at the start of a frame.

    localparam int h_total = h_active + h_blank;
    localparam int v_total = v_active + v_blank;

    localparam int h_cnt_w = $clog2(h_total);
    localparam int v_cnt_w = $clog2(v_total);

    // Pixel layout, line in the upper half and column in the lower half.
    localparam int pixel_w = 16;
    localparam int coord_w = pixel_w / 2;

    // Beats in a full frame packet.
    localparam int frame_beats = h_active * v_active;
    localparam int beat_cnt_w  = $clog2(frame_beats);

    // Output buffering.
    localparam int fifo_depth = 32;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = fifo_ptr_w + 1;  // Must hold fifo_depth itself.

    typedef logic [pixel_w-1:0] pixel_t;

    // One raster sample as seen on the native video side.
    typedef struct packed {
        logic   vs;
        logic   hs;
        logic   de;
        pixel_t data;
    } video_native_t;

    // One word of the packetized stream.
    typedef struct packed {
        pixel_t data;
        logic   last;
    } stream_beat_t;

endpackage

`default_nettype wire
